/* Makefile */
TB := tb_soc_peripherals

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+common --top-module soc_peripherals \
	  common/periph_pkg.sv rtl/sync_2ff.sv rtl/apb_periph_decode.sv \
	  gpio/gpio_bank.sv event_gen/soc_event_gen.sv rtl/soc_peripherals.sv

sim:
	verilator --binary --timing -f soc_peripherals.f --top-module $(TB) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* common/periph_params.svh */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// gpio bank geometry
`define N_GPIO_BANKS      4
`define GPIO_BANK_WIDTH   8

// apb bus widths
`define APB_ADDR_WIDTH    12
`define APB_DATA_WIDTH    32

// address map, slot in paddr[11:8] and word register in paddr[3:2]
`define SLOT_LSB          8
`define SLOT_IDX_WIDTH    4
`define N_SLOTS           5
`define EVT_SLOT          4
`define REG_IDX_LSB       2
`define REG_IDX_WIDTH     2

// gpio bank registers
`define GPIO_REG_OUT      2'd0
`define GPIO_REG_DIR      2'd1
`define GPIO_REG_IN       2'd2
`define GPIO_REG_IRQ_EN   2'd3

// event generator registers
`define EVT_REG_SW        2'd0
`define EVT_REG_MASK      2'd1
`define EVT_REG_STATUS    2'd2

// fc event vector layout
`define N_SW_EVENTS       7
`define FC_EVT_GPIO_POS   18
`define FC_EVT_REF_POS    23
`define FC_EVENTS_WIDTH   32

`endif

/* common/periph_pkg.sv */
`include "periph_params.svh"

package periph_pkg;

  // apb request from the bus master
  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic                       pwrite;
    logic                       psel;
    logic                       penable;
  } apb_req_t;

  // apb response back to the master
  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_rsp_t;

  // register access shared by all slots
  // we is only meaningful together with the slot select
  typedef struct packed {
    logic                       we;
    logic [`REG_IDX_WIDTH-1:0]  idx;
    logic [`APB_DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  // read word returned by a slot
  typedef logic [`APB_DATA_WIDTH-1:0] reg_rdata_t;

  // pins of one gpio bank
  typedef logic [`GPIO_BANK_WIDTH-1:0] gpio_word_t;

  // fabric controller event vector
  typedef logic [`FC_EVENTS_WIDTH-1:0] fc_events_t;

endpackage

/* event_gen/soc_event_gen.sv */
`timescale 1ns/10ps
`include "periph_params.svh"

module soc_event_gen (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  periph_pkg::reg_req_t     reg_req_i,
  input  logic                     sel_i,
  output periph_pkg::reg_rdata_t   rdata_o,
  input  logic [`N_GPIO_BANKS-1:0] gpio_evt_i,
  input  logic                     slow_clk_i,
  output periph_pkg::fc_events_t   fc_events_o
);

  logic                       ref_sync;
  logic                       ref_prev_q;
  logic                       ref_edge_q;
  logic                       wr_sw;
  logic                       wr_mask;
  logic                       wr_status;
  logic [`N_SW_EVENTS-1:0]    sw_evt;
  periph_pkg::fc_events_t     evt_raw;
  periph_pkg::fc_events_t     evt_masked;
  periph_pkg::fc_events_t     status_clr;
  periph_pkg::fc_events_t     mask_q;
  periph_pkg::fc_events_t     status_q;
  periph_pkg::fc_events_t     fc_events_q;

  //////////////////////////////////////////////////////////////////////
  // reference clock edges
  //////////////////////////////////////////////////////////////////////

  // slow clock is asynchronous to clk_i
  sync_2ff #(
    .T(logic)
  ) i_ref_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .d_i     (slow_clk_i),
    .q_o     (ref_sync)
  );

  // rise or fall, one cycle wide, registered to match the gpio path
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ref_prev_q <= 1'b0;
      ref_edge_q <= 1'b0;
    end else begin
      ref_prev_q <= ref_sync;
      ref_edge_q <= ref_sync ^ ref_prev_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register writes and event merge
  //////////////////////////////////////////////////////////////////////

  assign wr_sw     = sel_i & reg_req_i.we & (reg_req_i.idx == `EVT_REG_SW);
  assign wr_mask   = sel_i & reg_req_i.we & (reg_req_i.idx == `EVT_REG_MASK);
  assign wr_status = sel_i & reg_req_i.we & (reg_req_i.idx == `EVT_REG_STATUS);

  // sw events live for the access cycle only
  assign sw_evt = wr_sw ? reg_req_i.wdata[`N_SW_EVENTS-1:0] : '0;

  // write one to clear
  assign status_clr = wr_status ? reg_req_i.wdata : '0;

  // fixed positions in the fc vector
  always_comb begin
    evt_raw = '0;
    evt_raw[`N_SW_EVENTS-1:0] = sw_evt;
    evt_raw[`FC_EVT_GPIO_POS +: `N_GPIO_BANKS] = gpio_evt_i;
    evt_raw[`FC_EVT_REF_POS] = ref_edge_q;
  end

  assign evt_masked = evt_raw & mask_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // every event enabled out of reset
      mask_q      <= '1;
      status_q    <= '0;
      fc_events_q <= '0;
    end else begin
      if (wr_mask) begin
        mask_q <= reg_req_i.wdata;
      end
      // a new event wins over a clear of the same bit
      status_q    <= (status_q & ~status_clr) | evt_masked;
      fc_events_q <= evt_masked;
    end
  end

  assign fc_events_o = fc_events_q;

  // SW is write only
  always_comb begin
    case (reg_req_i.idx)
      `EVT_REG_MASK:   rdata_o = mask_q;
      `EVT_REG_STATUS: rdata_o = status_q;
      default:         rdata_o = '0;
    endcase
  end

endmodule

/* gpio/gpio_bank.sv */
`timescale 1ns/10ps
`include "periph_params.svh"

module gpio_bank (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  periph_pkg::reg_req_t   reg_req_i,
  input  logic                   sel_i,
  output periph_pkg::reg_rdata_t rdata_o,
  input  periph_pkg::gpio_word_t gpio_in_i,
  output periph_pkg::gpio_word_t gpio_out_o,
  output periph_pkg::gpio_word_t gpio_oe_o,
  output logic                   irq_o
);

  periph_pkg::gpio_word_t out_q;
  periph_pkg::gpio_word_t dir_q;
  periph_pkg::gpio_word_t irq_en_q;
  periph_pkg::gpio_word_t in_sync;
  periph_pkg::gpio_word_t in_prev_q;
  periph_pkg::gpio_word_t rise;
  logic                   irq_q;
  logic                   wr_out;
  logic                   wr_dir;
  logic                   wr_irq_en;

  //////////////////////////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////////////////////////

  // pins land in IN two edges after sampling
  sync_2ff #(
    .T(periph_pkg::gpio_word_t)
  ) i_in_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .d_i     (gpio_in_i),
    .q_o     (in_sync)
  );

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  // IN has no write strobe, writes to it are dropped
  assign wr_out    = sel_i & reg_req_i.we & (reg_req_i.idx == `GPIO_REG_OUT);
  assign wr_dir    = sel_i & reg_req_i.we & (reg_req_i.idx == `GPIO_REG_DIR);
  assign wr_irq_en = sel_i & reg_req_i.we & (reg_req_i.idx == `GPIO_REG_IRQ_EN);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q    <= '0;
      dir_q    <= '0;
      irq_en_q <= '0;
    end else begin
      if (wr_out) begin
        out_q <= reg_req_i.wdata[`GPIO_BANK_WIDTH-1:0];
      end
      if (wr_dir) begin
        dir_q <= reg_req_i.wdata[`GPIO_BANK_WIDTH-1:0];
      end
      if (wr_irq_en) begin
        irq_en_q <= reg_req_i.wdata[`GPIO_BANK_WIDTH-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // rising edge interrupt
  //////////////////////////////////////////////////////////////////////

  // enabled pins that were low and are now high
  assign rise = in_sync & ~in_prev_q & irq_en_q;

  // strobe registered, so it leaves on the third edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_prev_q <= '0;
      irq_q     <= 1'b0;
    end else begin
      in_prev_q <= in_sync;
      irq_q     <= |rise;
    end
  end

  assign irq_o = irq_q;

  // read mux, zero extended to the bus width
  always_comb begin
    rdata_o = '0;
    case (reg_req_i.idx)
      `GPIO_REG_OUT:    rdata_o[`GPIO_BANK_WIDTH-1:0] = out_q;
      `GPIO_REG_DIR:    rdata_o[`GPIO_BANK_WIDTH-1:0] = dir_q;
      `GPIO_REG_IN:     rdata_o[`GPIO_BANK_WIDTH-1:0] = in_sync;
      `GPIO_REG_IRQ_EN: rdata_o[`GPIO_BANK_WIDTH-1:0] = irq_en_q;
      default:          rdata_o = '0;
    endcase
  end

  // pad side
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

/* rtl/apb_periph_decode.sv */
`timescale 1ns/10ps
`include "periph_params.svh"

module apb_periph_decode (
  input  periph_pkg::apb_req_t                    apb_req_i,
  output periph_pkg::apb_rsp_t                    apb_rsp_o,
  output periph_pkg::reg_req_t                    reg_req_o,
  output logic [`N_SLOTS-1:0]                     slot_sel_o,
  input  periph_pkg::reg_rdata_t [`N_SLOTS-1:0]   slot_rdata_i
);

  logic [`SLOT_IDX_WIDTH-1:0] slot_idx;
  logic                       access;
  logic                       slot_valid;
  periph_pkg::reg_rdata_t     rdata_mux;

  // access phase of the transfer
  assign access = apb_req_i.psel & apb_req_i.penable;

  // slot index from the upper address bits
  assign slot_idx = apb_req_i.paddr[`SLOT_LSB +: `SLOT_IDX_WIDTH];

  // slots 5 to 15 are unmapped
  assign slot_valid = (slot_idx < `SLOT_IDX_WIDTH'(`N_SLOTS));

  //////////////////////////////////////////////////////////////////////
  // shared register request
  //////////////////////////////////////////////////////////////////////

  // write strobe only in the access phase of a mapped slot
  assign reg_req_o.we    = access & apb_req_i.pwrite & slot_valid;
  assign reg_req_o.idx   = apb_req_i.paddr[`REG_IDX_LSB +: `REG_IDX_WIDTH];
  assign reg_req_o.wdata = apb_req_i.pwdata;

  //////////////////////////////////////////////////////////////////////
  // slot select and read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    slot_sel_o = '0;
    rdata_mux  = '0;
    for (int s = 0; s < `N_SLOTS; s++) begin
      if (slot_idx == `SLOT_IDX_WIDTH'(s)) begin
        // select only during the access cycle
        slot_sel_o[s] = access;
        rdata_mux     = slot_rdata_i[s];
      end
    end
  end

  // unmapped slot falls through the loop with zero read data
  assign apb_rsp_o.prdata = rdata_mux;

  // zero wait states, slaves never stall
  assign apb_rsp_o.pready = 1'b1;

  // error response for an unmapped slot
  assign apb_rsp_o.pslverr = access & ~slot_valid;

endmodule

/* rtl/soc_peripherals.sv */
`timescale 1ns/10ps
`include "periph_params.svh"

module soc_peripherals (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         slow_clk_i,
  input  periph_pkg::apb_req_t                         apb_req_i,
  output periph_pkg::apb_rsp_t                         apb_rsp_o,
  input  periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0]   gpio_in_i,
  output periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0]   gpio_out_o,
  output periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0]   gpio_oe_o,
  output periph_pkg::fc_events_t                       fc_events_o
);

  periph_pkg::reg_req_t                    reg_req;
  logic [`N_SLOTS-1:0]                     slot_sel;
  periph_pkg::reg_rdata_t [`N_SLOTS-1:0]   slot_rdata;
  logic [`N_GPIO_BANKS-1:0]                gpio_evt;

  //////////////////////////////////////////////////////////////////////
  // apb decode
  //////////////////////////////////////////////////////////////////////

  apb_periph_decode i_decode (
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .reg_req_o   (reg_req),
    .slot_sel_o  (slot_sel),
    .slot_rdata_i(slot_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // gpio banks in slots 0 to 3
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `N_GPIO_BANKS; i++) begin : g_gpio_bank
    gpio_bank i_gpio_bank (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .reg_req_i (reg_req),
      .sel_i     (slot_sel[i]),
      .rdata_o   (slot_rdata[i]),
      .gpio_in_i (gpio_in_i[i]),
      .gpio_out_o(gpio_out_o[i]),
      .gpio_oe_o (gpio_oe_o[i]),
      .irq_o     (gpio_evt[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // event generator in slot 4
  //////////////////////////////////////////////////////////////////////

  // collects the bank strobes and the slow clock edges
  soc_event_gen i_event_gen (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .reg_req_i  (reg_req),
    .sel_i      (slot_sel[`EVT_SLOT]),
    .rdata_o    (slot_rdata[`EVT_SLOT]),
    .gpio_evt_i (gpio_evt),
    .slow_clk_i (slow_clk_i),
    .fc_events_o(fc_events_o)
  );

endmodule

/* rtl/sync_2ff.sv */
`timescale 1ns/10ps

module sync_2ff #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  T     d_i,
  output T     q_o
);

  // first stage may go metastable
  T meta_q;
  T sync_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

/* soc_peripherals.f */
+incdir+common
common/periph_pkg.sv
rtl/sync_2ff.sv
rtl/apb_periph_decode.sv
gpio/gpio_bank.sv
event_gen/soc_event_gen.sv
rtl/soc_peripherals.sv
verification/tb_soc_peripherals.sv

/* verification/tb_soc_peripherals.sv */
`timescale 1ns/10ps
`include "periph_params.svh"

module tb_soc_peripherals;

  localparam int EVT = `EVT_SLOT;

  logic                                       clk;
  logic                                       arst_n;
  logic                                       slow_clk;
  periph_pkg::apb_req_t                       apb_req;
  periph_pkg::apb_rsp_t                       apb_rsp;
  periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0] gpio_in;
  periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0] gpio_out;
  periph_pkg::gpio_word_t [`N_GPIO_BANKS-1:0] gpio_oe;
  periph_pkg::fc_events_t                     fc_events;

  logic [31:0]            lfsr;
  int                     errors;
  // register model
  periph_pkg::gpio_word_t m_out [`N_GPIO_BANKS];
  periph_pkg::gpio_word_t m_dir [`N_GPIO_BANKS];
  periph_pkg::gpio_word_t m_in [`N_GPIO_BANKS];
  periph_pkg::gpio_word_t m_irq_en [`N_GPIO_BANKS];
  periph_pkg::fc_events_t m_mask;
  periph_pkg::fc_events_t m_status;

  soc_peripherals dut_i (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .slow_clk_i (slow_clk),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .fc_events_o(fc_events)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // expected bank register zero extended to the bus
  function automatic logic [31:0] gpio_model(input int bank, input logic [1:0] idx);
    case (idx)
      `GPIO_REG_OUT: return 32'(m_out[bank]);
      `GPIO_REG_DIR: return 32'(m_dir[bank]);
      `GPIO_REG_IN:  return 32'(m_in[bank]);
      default:       return 32'(m_irq_en[bank]);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // apb master
  //////////////////////////////////////////////////////////////////////

  // setup then access and return just after the access edge
  task automatic apb_xfer(input logic [11:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clk);
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    apb_req.pwrite  <= write;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1 && wait_cnt < 16) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (apb_rsp.pready !== 1'b1) begin
      errors++;
      $display("timeout at %0t: pready never came for address %h", $time, addr);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  task automatic reg_write(input int slot, input logic [1:0] idx, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer({4'(slot), 4'h0, idx, 2'b00}, 1'b1, data, rd, err);
    if (err !== 1'b0) begin
      errors++;
      $display("unexpected pslverr on write to slot %0d at %0t", slot, $time);
    end
  endtask

  task automatic read_check(input int slot, input logic [1:0] idx, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    logic        err;
    apb_xfer({4'(slot), 4'h0, idx, 2'b00}, 1'b0, 32'h0, rd, err);
    if (err !== 1'b0) begin
      errors++;
      $display("unexpected pslverr on read of %s at %0t", name, $time);
    end
    if (rd !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, rd, exp);
    end
  endtask

  // watch one event bit for a 6 cycle window
  task automatic expect_pulses(input int pos, input int exp, input string name);
    int n;
    n = 0;
    for (int c = 0; c < 6; c++) begin
      @(negedge clk);
      if (fc_events[pos]) n++;
    end
    if (n == 0 && exp > 0) begin
      errors++;
      $display("no %s pulse on fc_events_o[%0d] within 6 cycles at %0t", name, pos, $time);
    end else if (n != exp) begin
      errors++;
      $display("mismatch at %0t: fc_events_o[%0d] pulses got %0d expected %0d",
               $time, pos, n, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]             data;
    logic [31:0]             rd;
    logic                    err;
    logic [1:0]              idx;
    logic [2:0]              pin;
    logic [`N_SW_EVENTS-1:0] sw_exp;
    int                      b;

    lfsr     = 32'h9a46b0ef;
    errors   = 0;
    arst_n   <= 1'b0;
    slow_clk <= 1'b0;
    apb_req  <= '0;
    gpio_in  <= '0;
    for (int i = 0; i < `N_GPIO_BANKS; i++) begin
      m_out[i]    = '0;
      m_dir[i]    = '0;
      m_in[i]     = '0;
      m_irq_en[i] = '0;
    end
    m_mask   = '1;
    m_status = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // reset values
    @(negedge clk);
    if (gpio_out !== '0 || gpio_oe !== '0 || fc_events !== '0) begin
      errors++;
      $display("mismatch at %0t: gpio_out_o/gpio_oe_o/fc_events_o got %h/%h/%h expected zero",
               $time, gpio_out, gpio_oe, fc_events);
    end
    read_check(EVT, `EVT_REG_MASK, m_mask, "MASK");
    read_check(EVT, `EVT_REG_STATUS, m_status, "STATUS");

    // random OUT DIR IRQ_EN writes with the pads following a cycle later
    for (int n = 0; n < 40; n++) begin
      b   = rand_bits(2);
      idx = 2'(rand_bits(2));
      if (idx == `GPIO_REG_IN) idx = `GPIO_REG_IRQ_EN;
      data = rand_bits(32);
      reg_write(b, idx, data);
      case (idx)
        `GPIO_REG_OUT: m_out[b] = data[7:0];
        `GPIO_REG_DIR: m_dir[b] = data[7:0];
        default:       m_irq_en[b] = data[7:0];
      endcase
      @(negedge clk);
      if (gpio_out[b] !== m_out[b] || gpio_oe[b] !== m_dir[b]) begin
        errors++;
        $display("mismatch at %0t: gpio_out_o/gpio_oe_o[%0d] got %h/%h expected %h/%h",
                 $time, b, gpio_out[b], gpio_oe[b], m_out[b], m_dir[b]);
      end
      read_check(b, idx, gpio_model(b, idx), $sformatf("bank%0d reg%0d", b, idx));
    end
    for (int i = 0; i < `N_GPIO_BANKS; i++) begin
      reg_write(i, `GPIO_REG_IRQ_EN, 32'h0);
      m_irq_en[i] = '0;
    end

    // input sync and writes to the read only IN
    for (int n = 0; n < 8; n++) begin
      b    = rand_bits(2);
      data = rand_bits(8);
      m_in[b] = data[7:0];
      @(posedge clk);
      gpio_in[b] <= data[7:0];
      repeat (3) @(posedge clk);
      read_check(b, `GPIO_REG_IN, gpio_model(b, `GPIO_REG_IN), "IN");
      reg_write(b, `GPIO_REG_IN, rand_bits(32));
      read_check(b, `GPIO_REG_IN, gpio_model(b, `GPIO_REG_IN), "IN after write");
      read_check(b, `GPIO_REG_OUT, gpio_model(b, `GPIO_REG_OUT), "OUT after IN write");
    end
    @(posedge clk);
    gpio_in <= '0;
    for (int i = 0; i < `N_GPIO_BANKS; i++) m_in[i] = '0;
    repeat (3) @(posedge clk);

    // gpio edge events per bank
    for (int bk = 0; bk < `N_GPIO_BANKS; bk++) begin
      pin  = 3'(rand_bits(3));
      data = rand_bits(8) | (32'h1 << pin);
      reg_write(bk, `GPIO_REG_IRQ_EN, data);
      m_irq_en[bk] = data[7:0];
      @(posedge clk);
      gpio_in[bk][pin] <= 1'b1;
      expect_pulses(`FC_EVT_GPIO_POS + bk, 1, "enabled rise");
      m_status[`FC_EVT_GPIO_POS + bk] = 1'b1;
      @(posedge clk);
      gpio_in[bk][pin] <= 1'b0;
      expect_pulses(`FC_EVT_GPIO_POS + bk, 0, "fall");
      // same pin with its enable cleared
      data = data & ~(32'h1 << pin);
      reg_write(bk, `GPIO_REG_IRQ_EN, data);
      m_irq_en[bk] = data[7:0];
      @(posedge clk);
      gpio_in[bk][pin] <= 1'b1;
      expect_pulses(`FC_EVT_GPIO_POS + bk, 0, "disabled rise");
      @(posedge clk);
      gpio_in[bk][pin] <= 1'b0;
      expect_pulses(`FC_EVT_GPIO_POS + bk, 0, "fall");
      reg_write(bk, `GPIO_REG_IRQ_EN, 32'h0);
      m_irq_en[bk] = '0;
    end

    // software events through a random mask
    m_mask = rand_bits(32);
    reg_write(EVT, `EVT_REG_MASK, m_mask);
    read_check(EVT, `EVT_REG_MASK, m_mask, "MASK");
    for (int n = 0; n < 8; n++) begin
      data = rand_bits(32);
      reg_write(EVT, `EVT_REG_SW, data);
      sw_exp = data[`N_SW_EVENTS-1:0] & m_mask[`N_SW_EVENTS-1:0];
      m_status[`N_SW_EVENTS-1:0] = m_status[`N_SW_EVENTS-1:0] | sw_exp;
      @(negedge clk);
      if (fc_events[`N_SW_EVENTS-1:0] !== sw_exp) begin
        errors++;
        $display("mismatch at %0t: fc_events_o sw bits got %h expected %h",
                 $time, fc_events[`N_SW_EVENTS-1:0], sw_exp);
      end
      @(negedge clk);
      if (fc_events[`N_SW_EVENTS-1:0] !== '0) begin
        errors++;
        $display("sw event pulse lasted more than one cycle at %0t", $time);
      end
    end
    read_check(EVT, `EVT_REG_STATUS, m_status, "STATUS");
    read_check(EVT, `EVT_REG_SW, 32'h0, "SW");
    m_mask = '1;
    reg_write(EVT, `EVT_REG_MASK, m_mask);

    // slow clock toggles where both edges count
    for (int n = 0; n < 6; n++) begin
      @(posedge clk);
      slow_clk <= ~slow_clk;
      expect_pulses(`FC_EVT_REF_POS, 1, "reference edge");
      m_status[`FC_EVT_REF_POS] = 1'b1;
      repeat (rand_bits(2)) @(posedge clk);
    end
    read_check(EVT, `EVT_REG_STATUS, m_status, "STATUS");
    data = rand_bits(32);
    reg_write(EVT, `EVT_REG_STATUS, data);
    m_status = m_status & ~data;
    read_check(EVT, `EVT_REG_STATUS, m_status, "STATUS after clear");

    // unmapped slots 5 to 15
    for (int n = 0; n < 8; n++) begin
      b = rand_bits(4);
      if (b < `N_SLOTS) b = b + 11;
      idx = 2'(rand_bits(2));
      for (int w = 0; w < 2; w++) begin
        apb_xfer({4'(b), 4'h0, idx, 2'b00}, w == 0, rand_bits(32), rd, err);
        if (err !== 1'b1) begin
          errors++;
          $display("no pslverr for unmapped slot %0d at %0t", b, $time);
        end
        if (rd !== 32'h0) begin
          errors++;
          $display("mismatch at %0t: prdata got %h expected %h", $time, rd, 32'h0);
        end
      end
    end
    for (int i = 0; i < `N_GPIO_BANKS; i++) begin
      for (int r = 0; r < 4; r++) begin
        read_check(i, 2'(r), gpio_model(i, 2'(r)), $sformatf("bank%0d reg%0d", i, r));
      end
    end
    read_check(EVT, `EVT_REG_MASK, m_mask, "MASK");
    read_check(EVT, `EVT_REG_STATUS, m_status, "STATUS");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
